/* auto_sync/ll_auto_sync.sv */
// Online sequencing for the logic link
// Delays the transmit and receive online levels by programmed counts

`timescale 1ns/1ns

module ll_auto_sync import ll_pkg::*; (
  input  logic             clk_wr,
  input  logic             reset,
  input  logic             tx_online,
  input  logic             rx_online,
  input  logic [DLY_W-1:0] delay_x_value,
  input  logic [DLY_W-1:0] delay_y_value,
  output logic             tx_online_delay,
  output logic             rx_online_delay
);

  // Lane 0 is transmit, lane 1 is receive
  logic             cond  [2];
  logic [DLY_W-1:0] limit [2];
  logic [DLY_W-1:0] cnt   [2];
  logic             level [2];

  ////////////////////
  // Lane conditions

  // Transmit side waits on its own online only
  assign cond[0]  = tx_online;
  assign limit[0] = delay_x_value;

  // Receive side also needs the delayed transmit level
  assign cond[1]  = rx_online & level[0];
  assign limit[1] = delay_y_value;

  ////////////////////
  // Delay counters

  for (genvar i = 0; i < 2; i++) begin : g_lane
    always_ff @(posedge clk_wr) begin
      if (reset || !cond[i]) begin
        // Condition dropped, restart count and fall at once
        cnt[i]   <= '0;
        level[i] <= 1'b0;
      end else begin
        // Saturate so a long online stretch never wraps
        if (cnt[i] != '1) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
        // Zero delay rises on the first edge
        level[i] <= (cnt[i] >= limit[i]);
      end
    end
  end

  assign tx_online_delay = level[0];
  assign rx_online_delay = level[1];

endmodule

/* common/ll_pkg.sv */
// Logic link shared types and layout constants
// Channel words, link payload and the 320-bit PHY word

package ll_pkg;

  ////////////////////
  // Channel types

  // Width of one user channel
  localparam int CH_BITS = 79;

  // Width of the online delay counters and delay values
  localparam int DLY_W = 16;

  typedef logic [CH_BITS-1:0] ch_data_t;

  // Four channels, ch0 sits in the lowest bits
  typedef struct packed {
    ch_data_t ch3;
    ch_data_t ch2;
    ch_data_t ch1;
    ch_data_t ch0;
  } ch_bus_t;

  ////////////////////
  // Link and PHY words

  // Four channels worth of data
  typedef logic [4*CH_BITS-1:0] ll_payload_t;

  // Gen2 layout, marker on top then strobe then data
  typedef struct packed {
    logic [2:0]  marker;
    logic        stb;
    ll_payload_t payload;
  } phy_word_t;

  // Gen1 uses the lower half only
  localparam int GEN1_DATA_BITS = 158;
  localparam int GEN1_STB_POS   = 158;
  localparam int GEN1_MRK_POS   = 159;

  // Fixed gen2 marker, no user markers
  localparam logic [2:0] GEN2_MARKER = 3'b000;

  ////////////////////
  // Debug status layout

  localparam int DBG_TX_ONLINE_BIT = 19;
  localparam int DBG_RX_ONLINE_BIT = 18;

endpackage

/* link/ll_channel_pack.sv */
// Channel packer for the transmit path
// Places the user channels into the link payload by link mode

`timescale 1ns/1ns

module ll_channel_pack import ll_pkg::*; (
  input  logic        m_gen2_mode,
  input  ch_bus_t     ch_tx,
  output ll_payload_t payload
);

  // Gen1 carries only two channels
  logic [GEN1_DATA_BITS-1:0] gen1_data;

  assign gen1_data = {ch_tx.ch1, ch_tx.ch0};

  ////////////////////
  // Mode select

  always_comb begin
    if (m_gen2_mode) begin
      // All four channels, ch0 at bit 0
      payload = ch_tx;
    end else begin
      // Lower data bits only
      // zero above so the framer can drop its strobe and marker in
      payload                     = '0;
      payload[GEN1_DATA_BITS-1:0] = gen1_data;
    end
  end

endmodule

/* link/ll_channel_unpack.sv */
// Channel unpacker for the receive path
// Splits the accepted link payload back into user channels by mode

`timescale 1ns/1ns

module ll_channel_unpack import ll_pkg::*; (
  input  logic        m_gen2_mode,
  input  ll_payload_t rx_payload,
  output ch_bus_t     ch_rx
);

  // Full slicing, ch0 from the lowest bits
  ch_bus_t all_ch;

  assign all_ch = rx_payload;

  ////////////////////
  // Mode select

  always_comb begin
    // Acceptance is already done in the framer
    ch_rx = all_ch;
    if (!m_gen2_mode) begin
      // Gen1 has no upper channels
      ch_rx.ch2 = '0;
      ch_rx.ch3 = '0;
    end
  end

endmodule

/* link/ll_phy_framer.sv */
// PHY framer for the logic link
// Builds the strobed transmit PHY word and captures strobed receive words

`timescale 1ns/1ns

module ll_phy_framer import ll_pkg::*; (
  input  logic        clk_wr,
  input  logic        reset,
  input  logic        m_gen2_mode,
  input  logic        tx_online,
  input  logic        rx_online,
  input  ll_payload_t tx_payload,
  input  phy_word_t   rx_phy0,
  output phy_word_t   tx_phy0,
  output ll_payload_t rx_payload
);

  phy_word_t   tx_word;
  logic        rx_stb;
  ll_payload_t rx_data;

  ////////////////////
  // Transmit framing

  always_comb begin
    tx_word         = '0;
    // Packer has already zeroed the gen1 upper half
    tx_word.payload = tx_payload;
    if (m_gen2_mode) begin
      tx_word.stb    = 1'b1;
      tx_word.marker = GEN2_MARKER;
    end else begin
      // Strobe and marker sit just above the gen1 data
      tx_word[GEN1_STB_POS] = 1'b1;
      // Fixed gen1 marker
      tx_word[GEN1_MRK_POS] = 1'b0;
    end
  end

  // One cycle from payload to PHY
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      // Idle link sends all zero
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_word;
    end
  end

  ////////////////////
  // Receive capture

  // Strobe position depends on mode
  assign rx_stb = m_gen2_mode ? rx_phy0.stb : rx_phy0[GEN1_STB_POS];

  always_comb begin
    if (m_gen2_mode) begin
      rx_data = rx_phy0.payload;
    end else begin
      // Strip gen1 strobe, marker and upper half
      rx_data                     = '0;
      rx_data[GEN1_DATA_BITS-1:0] = rx_phy0.payload[GEN1_DATA_BITS-1:0];
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online) begin
      rx_payload <= '0;
    end else if (rx_stb) begin
      rx_payload <= rx_data;
    end
    // Unstrobed words hold the last accepted payload
  end

endmodule

/* tests/ll_multi_channel_tb.sv */
// Directed testbench for the four channel logic link
// Online sequencing, gen1 and gen2 framing, loopback and strobe gating

`timescale 1ns/1ns

module ll_multi_channel_tb import ll_pkg::*; ();

  // Cycle budget of all tests, used by the watchdog
  localparam int CLK_NS     = 40;
  localparam int TEST_CYC   = 8 + 6 + 16 + 14 + 12 + 24 + 10;
  localparam int MARGIN_CYC = 40;

  logic             clk_wr;
  logic             reset;
  logic             tx_online;
  logic             rx_online;
  logic [DLY_W-1:0] delay_x_value;
  logic [DLY_W-1:0] delay_y_value;
  logic             m_gen2_mode;
  logic             loopback;
  phy_word_t        rx_phy_drv;
  phy_word_t        rx_phy0;
  phy_word_t        tx_phy0;
  ch_bus_t          ch_tx;
  ch_bus_t          ch_rx;
  logic [31:0]      debug_status;
  logic [31:0]      rng_state;
  int               error_count;
  int               tests_run;
  int               tests_failed;

  tb_clock u_clock (.clk_wr(clk_wr), .reset(reset));

  // Loopback switch on the PHY side
  assign rx_phy0 = loopback ? tx_phy0 : rx_phy_drv;

  ll_multi_channel_top dut0 (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .m_gen2_mode   (m_gen2_mode),
    .rx_phy0       (rx_phy0),
    .tx_phy0       (tx_phy0),
    .ch_tx         (ch_tx),
    .ch_rx         (ch_rx),
    .debug_status  (debug_status)
  );

  ////////////////////
  // Stimulus helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Ten random words cover the 316 channel bits
  task automatic random_bus(output ch_bus_t bus);
    logic [319:0] bits;
    for (int i = 0; i < 10; i++) begin
      rng_state        = xorshift32(rng_state);
      bits[i*32 +: 32] = rng_state;
    end
    bus = bits[315:0];
  endtask

  // Expected PHY word, gen2 full width or gen1 lower half
  function automatic phy_word_t frame_expected(input ch_bus_t ch, input logic gen2);
    phy_word_t w;
    w = '0;
    if (gen2) begin
      w.marker  = 3'b000;
      w.stb     = 1'b1;
      w.payload = {ch.ch3, ch.ch2, ch.ch1, ch.ch0};
    end else begin
      w[157:0] = {ch.ch1, ch.ch0};
      w[158]   = 1'b1;
    end
    return w;
  endfunction

  function automatic phy_word_t build_rx_word(input ch_bus_t ch, input logic stb);
    phy_word_t w;
    w.marker  = 3'b000;
    w.stb     = stb;
    w.payload = ch;
    return w;
  endfunction

  task automatic next_cycle();
    @(negedge clk_wr);
  endtask

  ////////////////////
  // Compare tasks

  task automatic check_bus(input ch_bus_t got, input ch_bus_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_phy(input phy_word_t got, input phy_word_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_debug(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // Raise both online inputs and wait for both delayed levels
  task automatic bring_online(input int dx, input int dy);
    int waited;
    delay_x_value = dx;
    delay_y_value = dy;
    tx_online     = 1'b1;
    rx_online     = 1'b1;
    waited        = 0;
    next_cycle();
    while ((debug_status[19] !== 1'b1 || debug_status[18] !== 1'b1) && waited <= dx + dy + 4) begin
      next_cycle();
      waited++;
    end
    if (debug_status[19] !== 1'b1 || debug_status[18] !== 1'b1) begin
      $display("link did not come online within %0d cycles", waited);
      error_count++;
    end
  endtask

  ////////////////////
  // Tests

  task automatic test_reset_offline();
    int      errs;
    ch_bus_t bus;
    errs = error_count;
    check_phy(tx_phy0, '0, "tx_phy0 after reset");
    check_bus(ch_rx, '0, "ch_rx after reset");
    check_debug(debug_status, '0, "debug after reset");
    // Offline traffic must not leak through
    for (int i = 0; i < 4; i++) begin
      random_bus(bus);
      ch_tx      = bus;
      rx_phy_drv = build_rx_word(bus, 1'b1);
      next_cycle();
      check_phy(tx_phy0, '0, "tx_phy0 while offline");
      check_bus(ch_rx, '0, "ch_rx while offline");
      check_debug(debug_status, '0, "debug while offline");
    end
    report_test("reset_offline", errs);
  endtask

  task automatic test_online_delay();
    int          errs;
    logic [31:0] exp;
    errs          = error_count;
    delay_x_value = 6;
    delay_y_value = 3;
    tx_online     = 1'b1;
    rx_online     = 1'b1;
    // Tx rises after 7 edges, rx needs tx high plus 4 more
    for (int k = 1; k <= 12; k++) begin
      next_cycle();
      exp     = '0;
      exp[19] = (k >= 7);
      exp[18] = (k >= 11);
      check_debug(debug_status, exp, $sformatf("debug after %0d online cycles", k));
    end
    // Rx drops one edge after the delayed tx level
    tx_online = 1'b0;
    next_cycle();
    check_debug(debug_status, 32'h0004_0000, "debug one cycle after tx drop");
    next_cycle();
    check_debug(debug_status, '0, "debug two cycles after tx drop");
    rx_online = 1'b0;
    report_test("online_delay", errs);
  endtask

  task automatic test_gen2_tx();
    int      errs;
    ch_bus_t cur;
    errs        = error_count;
    m_gen2_mode = 1'b1;
    loopback    = 1'b0;
    bring_online(0, 0);
    for (int i = 0; i < 8; i++) begin
      random_bus(cur);
      ch_tx = cur;
      next_cycle();
      check_phy(tx_phy0, frame_expected(cur, 1'b1), "gen2 tx word");
    end
    report_test("gen2_tx", errs);
  endtask

  task automatic test_gen1_loopback();
    int      errs;
    ch_bus_t sent [6];
    ch_bus_t exp;
    errs        = error_count;
    m_gen2_mode = 1'b0;
    loopback    = 1'b1;
    for (int i = 0; i <= 6; i++) begin
      if (i < 6) begin
        random_bus(sent[i]);
        ch_tx = sent[i];
      end
      next_cycle();
      if (i < 6) begin
        check_phy(tx_phy0, frame_expected(sent[i], 1'b0), "gen1 tx word");
      end
      // Only the lower two channels come back
      if (i >= 1) begin
        exp     = '0;
        exp.ch0 = sent[i-1].ch0;
        exp.ch1 = sent[i-1].ch1;
        check_bus(ch_rx, exp, "gen1 loopback ch_rx");
      end
    end
    report_test("gen1_loopback", errs);
  endtask

  task automatic test_gen2_stream();
    int      errs;
    ch_bus_t sent [20];
    errs        = error_count;
    m_gen2_mode = 1'b1;
    loopback    = 1'b1;
    // Two edges from ch_tx to ch_rx
    for (int i = 0; i <= 20; i++) begin
      if (i < 20) begin
        random_bus(sent[i]);
        ch_tx = sent[i];
      end
      next_cycle();
      if (i >= 1) begin
        check_bus(ch_rx, sent[i-1], $sformatf("gen2 stream word %0d", i - 1));
      end
    end
    report_test("gen2_stream", errs);
  endtask

  task automatic test_strobe_gate();
    int      errs;
    ch_bus_t held;
    ch_bus_t other;
    errs        = error_count;
    m_gen2_mode = 1'b1;
    loopback    = 1'b0;
    random_bus(held);
    rx_phy_drv = build_rx_word(held, 1'b1);
    next_cycle();
    check_bus(ch_rx, held, "strobed word accepted");
    // Unstrobed words keep the last accepted value
    for (int i = 0; i < 2; i++) begin
      random_bus(other);
      rx_phy_drv = build_rx_word(other, 1'b0);
      next_cycle();
      check_bus(ch_rx, held, "unstrobed word ignored");
    end
    random_bus(other);
    rx_phy_drv = build_rx_word(other, 1'b1);
    next_cycle();
    check_bus(ch_rx, other, "next strobed word accepted");
    // Going offline clears everything again
    tx_online = 1'b0;
    rx_online = 1'b0;
    next_cycle();
    next_cycle();
    check_phy(tx_phy0, '0, "tx_phy0 after going offline");
    check_bus(ch_rx, '0, "ch_rx after going offline");
    check_debug(debug_status, '0, "debug after going offline");
    report_test("strobe_gate", errs);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    m_gen2_mode   = 1'b1;
    loopback      = 1'b0;
    rx_phy_drv    = '0;
    ch_tx         = '0;
    rng_state     = 32'h59bc;
    error_count   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    wait (!reset);
    next_cycle();
    test_reset_offline();
    test_online_delay();
    test_gen2_tx();
    test_gen1_loopback();
    test_gen2_stream();
    test_strobe_gate();
    $display("summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((TEST_CYC + MARGIN_CYC) * CLK_NS);
    $display("timeout: the tests did not finish in the expected time");
    $display("Some tests failed");
    $finish;
  end

endmodule

/* tests/tb_clock.sv */
// Testbench clock and reset generator
// 40 ns clock, synchronous reset held for five cycles

`timescale 1ns/1ns

module tb_clock (
  output logic clk_wr,
  output logic reset
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_wr = 1'b0;
    forever #HALF_PERIOD clk_wr = ~clk_wr;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    @(negedge clk_wr);
    reset = 1'b0;
  end

endmodule

/* verilog.f */
common/ll_pkg.sv
auto_sync/ll_auto_sync.sv
link/ll_channel_pack.sv
link/ll_phy_framer.sv
link/ll_channel_unpack.sv
verilog/ll_multi_channel_top.sv
tests/tb_clock.sv
tests/ll_multi_channel_tb.sv

/* verilog/ll_multi_channel_top.sv */
// Four channel logic link top level
// Online sequencing, channel packing, PHY framing and unpacking

`timescale 1ns/1ns

module ll_multi_channel_top import ll_pkg::*; (
  input  logic             clk_wr,
  input  logic             reset,

  // Link control
  input  logic             tx_online,
  input  logic             rx_online,
  input  logic [DLY_W-1:0] delay_x_value,
  input  logic [DLY_W-1:0] delay_y_value,
  input  logic             m_gen2_mode,

  // PHY side
  input  phy_word_t        rx_phy0,
  output phy_word_t        tx_phy0,

  // User channels
  input  ch_bus_t          ch_tx,
  output ch_bus_t          ch_rx,

  output logic [31:0]      debug_status
);

  logic        tx_online_delay;
  logic        rx_online_delay;
  ll_payload_t tx_payload;
  ll_payload_t rx_payload;

  ////////////////////
  // Online sequencing

  ll_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////
  // Producer

  ll_channel_pack u_channel_pack (
    .m_gen2_mode (m_gen2_mode),
    .ch_tx       (ch_tx),
    .payload     (tx_payload)
  );

  // Framer runs on the delayed levels
  ll_phy_framer u_phy_framer (
    .clk_wr      (clk_wr),
    .reset       (reset),
    .m_gen2_mode (m_gen2_mode),
    .tx_online   (tx_online_delay),
    .rx_online   (rx_online_delay),
    .tx_payload  (tx_payload),
    .rx_phy0     (rx_phy0),
    .tx_phy0     (tx_phy0),
    .rx_payload  (rx_payload)
  );

  ////////////////////
  // Consumer

  ll_channel_unpack u_channel_unpack (
    .m_gen2_mode (m_gen2_mode),
    .rx_payload  (rx_payload),
    .ch_rx       (ch_rx)
  );

  // Debug word, only the two delayed online levels
  always_comb begin
    debug_status                    = '0;
    debug_status[DBG_TX_ONLINE_BIT] = tx_online_delay;
    debug_status[DBG_RX_ONLINE_BIT] = rx_online_delay;
  end

endmodule
